// File: run_sim.sh
#!/bin/sh
# Build and run the flash reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module spix_tb -f spix.f -Mdir obj_dir -o spix_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/spix_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: source/spix_flash_reader.sv
`timescale 1ns/100ps
////////////////////////////////////////
// Flash read controller top level
// Sequencer and shifter on one bus slave port
////////////////////////////////////////
module spix_flash_reader
(
	input  logic                              i_clk,
	input  logic                              i_reset,
	// Pipelined bus slave
	input  logic                              i_wb_cyc,
	input  logic                              i_wb_stb,
	input  logic                              i_cfg_stb,
	input  logic                              i_wb_we,
	input  logic [spix_pkg::SPIX_ADDR_W-1:0]  i_wb_addr,
	input  logic [spix_pkg::SPIX_DATA_W-1:0]  i_wb_data,
	output logic                              o_wb_stall,
	output logic                              o_wb_ack,
	output logic [spix_pkg::SPIX_DATA_W-1:0]  o_wb_data,
	// Serial flash
	output logic                              o_spi_cs_n,
	output logic                              o_spi_sck,
	output logic                              o_spi_mosi,
	input  logic                              i_spi_miso
);
	import spix_pkg::*;

	spix_shift_ctl_t shift_ctl;

	// Bus decode and transfer timing
	spix_sequencer u_sequencer
	(
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_cfg_stb   (i_cfg_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_addr   (i_wb_addr),
		// Only chip select and the byte matter on configuration writes
		.i_cfg_data  (i_wb_data[SPIX_CS_BIT:0]),
		.o_wb_stall  (o_wb_stall),
		.o_wb_ack    (o_wb_ack),
		.o_spi_cs_n  (o_spi_cs_n),
		.o_shift_ctl (shift_ctl)
	);

	// Serial data in and out
	spix_shifter u_shifter
	(
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_shift_ctl (shift_ctl),
		.i_spi_miso  (i_spi_miso),
		.o_spi_mosi  (o_spi_mosi),
		.o_spi_sck   (o_spi_sck),
		.o_wb_data   (o_wb_data)
	);

endmodule

// File: source/spix_pkg.sv
////////////////////////////////////////
// Shared definitions for the flash reader
// Widths, countdown constants, shifter opcodes
// and the sequencer to shifter control word
////////////////////////////////////////
package spix_pkg;

	// Bus side widths
	localparam int SPIX_ADDR_W = 22;
	localparam int SPIX_DATA_W = 32;

	// Command byte, address and two pad bits plus one idle bit on top
	localparam int SPIX_SHIFT_W = 33;

	// Serial read command
	localparam logic [7:0] SPIX_READ_CMD = 8'h03;

	// Bit time countdown
	localparam int SPIX_DELAY_W = 7;
	// Command, address and data bits plus the leading idle bit
	localparam logic [SPIX_DELAY_W-1:0] SPIX_DELAY_READ = 7'd65;
	// Data bits only while chip select stays low
	localparam logic [SPIX_DELAY_W-1:0] SPIX_DELAY_PIPE = 7'd32;
	// One byte plus the leading idle bit
	localparam logic [SPIX_DELAY_W-1:0] SPIX_DELAY_USER = 7'd9;

	// Chip select bit within the configuration word
	localparam int SPIX_CS_BIT = 8;

	// Shifter action for the current cycle
	typedef enum logic [1:0]
	{
		SPIX_OP_SHIFT     = 2'd0,
		SPIX_OP_LOAD_READ = 2'd1,
		SPIX_OP_LOAD_USER = 2'd2
	} spix_op_e;

	// Control word from sequencer to shifter
	typedef struct packed
	{
		spix_op_e               op;
		logic [SPIX_ADDR_W-1:0] addr;
		logic [7:0]             user_byte;
		logic                   sck;
		logic                   user_mode;
	} spix_shift_ctl_t;

endpackage

// File: source/spix_sequencer.sv
`timescale 1ns/100ps
////////////////////////////////////////
// Flash read sequencer
// Request decode, bit countdown, ack and stall
// User mode, chip select and flash clock
////////////////////////////////////////
module spix_sequencer
(
	input  logic                              i_clk,
	input  logic                              i_reset,
	input  logic                              i_wb_cyc,
	input  logic                              i_wb_stb,
	input  logic                              i_cfg_stb,
	input  logic                              i_wb_we,
	input  logic [spix_pkg::SPIX_ADDR_W-1:0]  i_wb_addr,
	input  logic [spix_pkg::SPIX_CS_BIT:0]    i_cfg_data,
	output logic                              o_wb_stall,
	output logic                              o_wb_ack,
	output logic                              o_spi_cs_n,
	output spix_pkg::spix_shift_ctl_t         o_shift_ctl
);
	import spix_pkg::*;

	// User mode owns the flash while chip select is held low
	logic                    cfg_user_mode;
	// Bit times left in the current transfer
	logic [SPIX_DELAY_W-1:0] ack_delay;
	// Flash clock as driven to the pin
	logic                    spi_sck;
	// Word address that may continue the current read
	logic [SPIX_ADDR_W-1:0]  next_addr;

	logic                    cfg_write;
	logic                    user_request;
	logic                    bus_request;
	logic                    next_request;

	////////////////////////////////////////
	// Request decode
	////////////////////////////////////////

	// Any accepted configuration write
	assign cfg_write = i_cfg_stb && !o_wb_stall && i_wb_we;

	// Bit 8 low starts a byte exchange
	assign user_request = cfg_write && !i_cfg_data[SPIX_CS_BIT];

	// Memory reads reach the flash only outside user mode
	assign bus_request = i_wb_stb && !o_wb_stall && !i_wb_we && !cfg_user_mode;

	// Read to the word right after the last one
	assign next_request = i_wb_stb && !i_wb_we && (i_wb_addr == next_addr);

	// Remember the following word of every accepted request
	always_ff @(posedge i_clk)
	begin
		if (i_wb_stb && !o_wb_stall)
			next_addr <= i_wb_addr + 1'b1;
	end

	////////////////////////////////////////
	// Countdown and acknowledge
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			ack_delay <= '0;
		else if (bus_request)
			// Skip command and address while the flash is still selected
			ack_delay <= o_spi_cs_n ? SPIX_DELAY_READ : SPIX_DELAY_PIPE;
		else if (user_request)
			ack_delay <= SPIX_DELAY_USER;
		else if (ack_delay != 0)
			ack_delay <= ack_delay - 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_ack <= 1'b0;
		// Last bit time of a transfer
		else if (ack_delay == 1)
			o_wb_ack <= i_wb_cyc;
		// Writes and user mode reads return at once
		else if (i_wb_stb && !o_wb_stall && !bus_request)
			o_wb_ack <= 1'b1;
		// Chip select release, or config reads
		else if (i_cfg_stb && !o_wb_stall && !user_request)
			o_wb_ack <= 1'b1;
		else
			o_wb_ack <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_wb_stall <= 1'b0;
		else if (bus_request || user_request)
			o_wb_stall <= 1'b1;
		// Open a slot for the next word one cycle before the end
		else if (next_request && (ack_delay == 2))
			o_wb_stall <= 1'b0;
		else
			o_wb_stall <= (ack_delay > 1);
	end

	////////////////////////////////////////
	// User mode, chip select, flash clock
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			cfg_user_mode <= 1'b0;
		else if (cfg_write)
			cfg_user_mode <= !i_cfg_data[SPIX_CS_BIT];
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_spi_cs_n <= 1'b1;
		// Aborted cycle releases the flash unless user mode holds it
		else if (!i_wb_cyc && !cfg_user_mode)
			o_spi_cs_n <= 1'b1;
		else if (bus_request)
			o_spi_cs_n <= 1'b0;
		else if (cfg_write)
			o_spi_cs_n <= i_cfg_data[SPIX_CS_BIT];
		else if (cfg_user_mode)
			o_spi_cs_n <= 1'b0;
		// End of read with no follow-on request
		else if (ack_delay == 1)
			o_spi_cs_n <= 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			spi_sck <= 1'b0;
		else if (bus_request || user_request)
			spi_sck <= 1'b1;
		else if (i_wb_cyc && (ack_delay > 2))
			spi_sck <= 1'b1;
		// Keep clocking straight into the next word
		else if (next_request && (ack_delay == 2))
			spi_sck <= 1'b1;
		else
			spi_sck <= 1'b0;
	end

	// Loads happen on the acceptance edge so op and addr come straight from the bus
	always_comb
	begin
		o_shift_ctl.op = SPIX_OP_SHIFT;
		if (bus_request)
			o_shift_ctl.op = SPIX_OP_LOAD_READ;
		else if (user_request)
			o_shift_ctl.op = SPIX_OP_LOAD_USER;
		o_shift_ctl.addr      = i_wb_addr;
		o_shift_ctl.user_byte = i_cfg_data[7:0];
		o_shift_ctl.sck       = spi_sck;
		o_shift_ctl.user_mode = cfg_user_mode;
	end

	////////////////////////////////////////
	// Invariants
	////////////////////////////////////////

	// No transfer is longer than a random read
	a_delay_max: assert property (@(posedge i_clk) disable iff (i_reset)
		ack_delay <= SPIX_DELAY_READ);

	// User mode only ever runs byte exchanges
	a_user_delay: assert property (@(posedge i_clk) disable iff (i_reset)
		cfg_user_mode |-> (ack_delay <= SPIX_DELAY_USER));

	// Flash never sees a clock while deselected
	a_sck_cs: assert property (@(posedge i_clk) disable iff (i_reset)
		o_spi_cs_n |-> !spi_sck);

	// Host is held off until the last bit time
	a_stall_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		(ack_delay > 1) |-> o_wb_stall);

endmodule

// File: source/spix_shifter.sv
`timescale 1ns/100ps
////////////////////////////////////////
// SPI data path
// Outgoing shift register, delayed clock
// and incoming word capture
////////////////////////////////////////
module spix_shifter
(
	input  logic                              i_clk,
	input  logic                              i_reset,
	input  logic                              i_wb_cyc,
	input  spix_pkg::spix_shift_ctl_t         i_shift_ctl,
	input  logic                              i_spi_miso,
	output logic                              o_spi_mosi,
	output logic                              o_spi_sck,
	output logic [spix_pkg::SPIX_DATA_W-1:0]  o_wb_data
);
	import spix_pkg::*;

	// Top bit drives MOSI
	logic [SPIX_SHIFT_W-1:0] wdata_pipe;
	// Flash clock one cycle late, marks valid MISO bits
	logic                    actual_sck;
	logic [SPIX_DATA_W-1:0]  data_next;

	////////////////////////////////////////
	// Outgoing bits
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wdata_pipe <= '0;
		else
		begin
			case (i_shift_ctl.op)
				// Idle bit, command, word address, two pad bits
				SPIX_OP_LOAD_READ:
					wdata_pipe <= {1'b0, SPIX_READ_CMD, i_shift_ctl.addr, 2'b00};
				// Idle bit then the user byte at the top
				SPIX_OP_LOAD_USER:
					wdata_pipe <= {1'b0, i_shift_ctl.user_byte,
						{(SPIX_SHIFT_W-9){1'b0}}};
				default:
					wdata_pipe <= {wdata_pipe[SPIX_SHIFT_W-2:0], 1'b0};
			endcase
		end
	end

	assign o_spi_mosi = wdata_pipe[SPIX_SHIFT_W-1];
	assign o_spi_sck  = i_shift_ctl.sck;

	////////////////////////////////////////
	// Incoming bits
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			actual_sck <= 1'b0;
		else
			actual_sck <= i_shift_ctl.sck;
	end

	always_comb
	begin
		if (i_shift_ctl.user_mode)
		begin
			// Byte only, with the released chip select value above it
			data_next = '0;
			data_next[SPIX_CS_BIT] = !i_shift_ctl.user_mode;
			data_next[7:0] = {o_wb_data[6:0], i_spi_miso};
		end
		else
			data_next = {o_wb_data[SPIX_DATA_W-2:0], i_spi_miso};
	end

	// Word is complete when the ack goes out
	always_ff @(posedge i_clk)
	begin
		if (actual_sck)
			o_wb_data <= data_next;
	end

endmodule

// File: spix.f
source/spix_pkg.sv
source/spix_sequencer.sv
source/spix_shifter.sv
source/spix_flash_reader.sv
verification/spix_flash_model.sv
verification/spix_tb.sv

// File: verification/spix_flash_model.sv
`timescale 1ns/100ps
////////////////////////////////////////
// Behavioral serial flash
// Answers the read command from a word array
// and echoes other bytes inverted
////////////////////////////////////////
module spix_flash_model
(
	input  logic        i_clk,
	input  logic        i_spi_cs_n,
	input  logic        i_spi_sck,
	input  logic        i_spi_mosi,
	// Word array, indexed by the low 12 address bits
	input  logic [31:0] i_mem [0:4095],
	output logic        o_spi_miso
);

	// Bit times since chip select fell
	int          bit_count = 0;
	// Command byte and word address as received
	logic [29:0] header;
	// Next data bit toward the controller
	logic        data_bit;

	// Header bit times echo MOSI inverted, later bits come from memory
	assign o_spi_miso = (bit_count < 33) ? !i_spi_mosi : data_bit;

	////////////////////////////////////////
	// One bit per enabled clock cycle
	////////////////////////////////////////
	always @(posedge i_clk)
	begin : bit_time
		int                n;
		logic [21:0]       word_addr;
		logic [31:0]       word;
		if (i_spi_cs_n)
		begin
			bit_count <= 0;
			data_bit  <= 1'b1;
		end
		else if (i_spi_sck)
		begin
			n = bit_count + 1;
			bit_count <= n;
			// Bit 1 is idle, then eight command and 22 address bits
			if ((n >= 2) && (n <= 31))
				header <= {header[28:0], i_spi_mosi};
			// Two pad bits, then words back to back, top bit first
			if (n >= 33)
			begin
				word_addr = header[21:0] + 22'((n - 33) / 32);
				word = i_mem[word_addr[11:0]];
				if (header[29:22] == 8'h03)
					data_bit <= word[31 - ((n - 33) % 32)];
				else
					data_bit <= 1'b1;
			end
		end
	end

endmodule

// File: verification/spix_tb.sv
`timescale 1ns/100ps
////////////////////////////////////////
// Testbench for the flash read controller
// Stimulus table, bus driver, flash model, checks
////////////////////////////////////////
module spix_tb;
	import spix_pkg::*;

	localparam int MEM_WORDS  = 4096;
	localparam int ROWS       = 8;
	// First word of any read that starts with chip select high
	localparam int LAT_RANDOM = 66;
	localparam int WAIT_LIMIT = 400;

	typedef enum int {OP_READ, OP_PIPE, OP_CFG, OP_MEMW, OP_RELEASE} tb_op_e;

	logic                   i_clk;
	logic                   i_reset;
	logic                   i_wb_cyc;
	logic                   i_wb_stb;
	logic                   i_cfg_stb;
	logic                   i_wb_we;
	logic [SPIX_ADDR_W-1:0] i_wb_addr;
	logic [SPIX_DATA_W-1:0] i_wb_data;
	logic                   o_wb_stall;
	logic                   o_wb_ack;
	logic [SPIX_DATA_W-1:0] o_wb_data;
	logic                   o_spi_cs_n;
	logic                   o_spi_sck;
	logic                   o_spi_mosi;
	logic                   i_spi_miso;

	// Same contents as the flash model
	logic [31:0]            flash_mem [0:MEM_WORDS-1];

	// Stimulus table
	string                  row_name    [ROWS];
	tb_op_e                 row_op      [ROWS];
	logic [31:0]            row_value   [ROWS];
	int                     row_latency [ROWS];

	int                     mismatch_count;
	int                     timeout_count;
	logic                   in_user_mode;

	spix_flash_reader dut
	(
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_cfg_stb  (i_cfg_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_addr  (i_wb_addr),
		.i_wb_data  (i_wb_data),
		.o_wb_stall (o_wb_stall),
		.o_wb_ack   (o_wb_ack),
		.o_wb_data  (o_wb_data),
		.o_spi_cs_n (o_spi_cs_n),
		.o_spi_sck  (o_spi_sck),
		.o_spi_mosi (o_spi_mosi),
		.i_spi_miso (i_spi_miso)
	);

	spix_flash_model flash
	(
		.i_clk      (i_clk),
		.i_spi_cs_n (o_spi_cs_n),
		.i_spi_sck  (o_spi_sck),
		.i_spi_mosi (o_spi_mosi),
		.i_mem      (flash_mem),
		.o_spi_miso (i_spi_miso)
	);

	// 100 ns clock
	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = !i_clk;
	end

	////////////////////////////////////////
	// Bus driver
	////////////////////////////////////////
	task automatic drive_request(input int r, input int idx);
		case (row_op[r])
			OP_READ, OP_PIPE:
			begin
				i_wb_stb  = 1'b1;
				i_wb_we   = 1'b0;
				i_wb_addr = row_value[r][SPIX_ADDR_W-1:0] + SPIX_ADDR_W'(idx);
			end
			OP_CFG, OP_RELEASE:
			begin
				i_cfg_stb = 1'b1;
				i_wb_we   = 1'b1;
				i_wb_data = row_value[r];
			end
			default:
			begin
				i_wb_stb  = 1'b1;
				i_wb_we   = 1'b1;
				i_wb_addr = row_value[r][SPIX_ADDR_W-1:0];
				i_wb_data = ~row_value[r];
			end
		endcase
	endtask

	task automatic drop_strobes();
		i_wb_stb  = 1'b0;
		i_cfg_stb = 1'b0;
		i_wb_we   = 1'b0;
	endtask

	// Issues one row, counts cycles from each acceptance edge to its ack
	task automatic run_row(input int r);
		int                     t;
		int                     issued;
		int                     acked;
		int                     total;
		int                     lat;
		int                     expect_lat;
		int                     accept_t [3];
		logic [SPIX_ADDR_W-1:0] word_addr;
		logic [31:0]            expect_word;
		logic [7:0]             mosi_bits;
		logic                   saw_sck;
		logic                   user_read;
		logic                   accept_now;
		total     = (row_op[r] == OP_PIPE) ? 3 : 1;
		user_read = in_user_mode && (row_op[r] == OP_READ);
		t         = 0;
		issued    = 0;
		acked     = 0;
		mosi_bits = '0;
		saw_sck   = 1'b0;
		// Flash reads start from a deselected flash
		if (!in_user_mode && (row_op[r] == OP_READ || row_op[r] == OP_PIPE)
			&& o_spi_cs_n !== 1'b1)
		begin
			$display("Mismatch %s cs_n before start: expected 1, actual %b",
				row_name[r], o_spi_cs_n);
			mismatch_count++;
		end
		i_wb_cyc = 1'b1;
		drive_request(r, 0);
		while ((acked < total) && (t < WAIT_LIMIT))
		begin
			// Stall holds its value until the next rising edge
			accept_now = (i_wb_stb || i_cfg_stb) && !o_wb_stall;
			@(negedge i_clk);
			t++;
			// Request went in on the rising edge just passed
			if (accept_now)
			begin
				accept_t[issued] = t - 1;
				issued++;
				if (issued < total)
					drive_request(r, issued);
				else
					drop_strobes();
			end
			if (o_spi_sck)
				saw_sck = 1'b1;
			// Byte bits sit on MOSI in cycles 2 to 9 after acceptance
			if (row_op[r] == OP_CFG && issued > 0
				&& (t - accept_t[0]) >= 2 && (t - accept_t[0]) <= 9)
				mosi_bits = {mosi_bits[6:0], o_spi_mosi};
			// Chip select stays low until the last word ends
			if (row_op[r] == OP_PIPE && issued > 0 && !(acked == 2 && o_wb_ack)
				&& o_spi_cs_n)
			begin
				$display("Mismatch %s cs_n between words: expected 0, actual 1",
					row_name[r]);
				mismatch_count++;
			end
			if (o_wb_ack && acked >= issued)
			begin
				$display("Acknowledge in %s arrived with no request pending", row_name[r]);
				mismatch_count++;
			end
			else if (o_wb_ack)
			begin
				lat = t - accept_t[acked];
				expect_lat = (row_op[r] == OP_PIPE && acked == 0) ? LAT_RANDOM
					: row_latency[r];
				if (lat != expect_lat)
				begin
					$display("Mismatch %s latency: expected %0d, actual %0d",
						row_name[r], expect_lat, lat);
					mismatch_count++;
				end
				if ((row_op[r] == OP_READ || row_op[r] == OP_PIPE) && !user_read)
				begin
					word_addr = row_value[r][SPIX_ADDR_W-1:0] + SPIX_ADDR_W'(acked);
					expect_word = flash_mem[word_addr[11:0]];
					if (o_wb_data !== expect_word)
					begin
						$display("Mismatch %s word %0d: expected %h, actual %h",
							row_name[r], acked, expect_word, o_wb_data);
						mismatch_count++;
					end
				end
				else if (row_op[r] == OP_CFG)
				begin
					// Echo is the inverted byte, bit 8 low while selected
					expect_word = {23'd0, 1'b0, ~row_value[r][7:0]};
					if (o_wb_data !== expect_word)
					begin
						$display("Mismatch %s data: expected %h, actual %h",
							row_name[r], expect_word, o_wb_data);
						mismatch_count++;
					end
				end
				else if ((row_op[r] == OP_RELEASE || row_op[r] == OP_MEMW)
					&& o_spi_cs_n !== 1'b1)
				begin
					$display("Mismatch %s cs_n: expected 1, actual %b",
						row_name[r], o_spi_cs_n);
					mismatch_count++;
				end
				if (row_op[r] == OP_MEMW && o_wb_stall !== 1'b0)
				begin
					$display("Mismatch %s stall: expected 0, actual %b",
						row_name[r], o_wb_stall);
					mismatch_count++;
				end
				acked++;
			end
		end
		if (acked < total)
		begin
			$display("Timed out in %s waiting for an acknowledge (%0d of %0d)",
				row_name[r], acked, total);
			timeout_count++;
		end
		drop_strobes();
		i_wb_cyc = 1'b0;
		if (row_op[r] == OP_CFG && mosi_bits !== row_value[r][7:0])
		begin
			$display("Mismatch %s mosi byte: expected %h, actual %h",
				row_name[r], row_value[r][7:0], mosi_bits);
			mismatch_count++;
		end
		// No flash clock for a read answered from user mode
		if (user_read && saw_sck)
		begin
			$display("Mismatch %s sck activity: expected 0, actual 1", row_name[r]);
			mismatch_count++;
		end
		if (row_op[r] == OP_CFG)
			in_user_mode = 1'b1;
		else if (row_op[r] == OP_RELEASE)
			in_user_mode = 1'b0;
		repeat (2) @(negedge i_clk);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial
	begin
		void'($urandom(84));
		i_reset        = 1'b1;
		i_wb_cyc       = 1'b0;
		i_wb_stb       = 1'b0;
		i_cfg_stb      = 1'b0;
		i_wb_we        = 1'b0;
		i_wb_addr      = '0;
		i_wb_data      = '0;
		mismatch_count = 0;
		timeout_count  = 0;
		in_user_mode   = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			flash_mem[i] = $urandom;

		// Name, operation, address or data, ack latency
		row_name    = '{"read_first", "read_pipe", "read_jump", "user_byte",
			"user_read", "user_byte2", "release", "mem_write"};
		row_op      = '{OP_READ, OP_PIPE, OP_READ, OP_CFG,
			OP_READ, OP_CFG, OP_RELEASE, OP_MEMW};
		row_value   = '{32'h0000_0123, 32'h0000_0200, 32'h0000_0a55, 32'h0000_00a5,
			32'h0000_0010, 32'h0000_003c, 32'h0000_0100, 32'h0000_0040};
		row_latency = '{66, 33, 66, 10, 1, 10, 1, 1};

		repeat (4) @(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);

		for (int r = 0; r < ROWS; r++)
			run_row(r);

		$display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
